// File: siso_pkg.sv
`default_nettype none

package siso_pkg;

	//////////////////////////////////////////////////
	// trellis size and metric format
	//////////////////////////////////////////////////

	localparam int NUM_STATES = 8;
	localparam int METRIC_W   = 16;

	// all metric arithmetic wraps at 16 bits, two's complement
	typedef logic signed [METRIC_W-1:0] metric_t;
	typedef metric_t [NUM_STATES-1:0] state_metrics_t;

	// beta start value of states 1 to 7, state 0 starts at zero
	localparam metric_t BETA_INIT_OTHER = -16'sd128;

	//////////////////////////////////////////////////
	// fixed trellis tables
	//////////////////////////////////////////////////

	// set bit selects g2, clear bit selects g1
	localparam bit [NUM_STATES-1:0] BRANCH_SEL = 8'b0011_1100;

	// beta index paired with each state
	localparam int NEXT_ONE  [NUM_STATES] = '{4, 0, 1, 5, 6, 2, 3, 7};
	localparam int NEXT_ZERO [NUM_STATES] = '{0, 4, 5, 1, 2, 6, 7, 3};

	// branch metric used by state s
	function automatic metric_t sel_branch(input int s, input metric_t g1, input metric_t g2);
		return BRANCH_SEL[s] ? g2 : g1;
	endfunction

	// signed max of two metrics
	function automatic metric_t metric_max(input metric_t a, input metric_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

`default_nettype wire

// File: stream_pkg.sv
`default_nettype none

package stream_pkg;

	import siso_pkg::*;

	//////////////////////////////////////////////////
	// block size
	//////////////////////////////////////////////////

	localparam int MAX_BLOCK_LEN = 512;
	localparam int BLK_ADDR_W    = $clog2(MAX_BLOCK_LEN);

	// length runs 1 to MAX_BLOCK_LEN, so one bit wider than an address
	typedef logic [BLK_ADDR_W:0]   blk_len_t;
	typedef logic [BLK_ADDR_W-1:0] blk_addr_t;

	//////////////////////////////////////////////////
	// output credits
	//////////////////////////////////////////////////

	typedef logic [2:0] credit_cnt_t;
	localparam credit_cnt_t CREDIT_MAX = 3'd4;

	//////////////////////////////////////////////////
	// port payloads
	//////////////////////////////////////////////////

	// per step channel data, 64 bits
	typedef struct packed {
		metric_t sys;
		metric_t apriori;
		metric_t g1;
		metric_t g2;
	} chan_sym_t;

	// forward state metrics of one step
	typedef struct packed {
		state_metrics_t alpha;
	} alpha_sym_t;

	typedef struct packed {
		metric_t extrinsic;
		logic    last;
	} ext_out_t;

endpackage

`default_nettype wire

// File: block_lifo.sv
`timescale 1ns/100ps
`default_nettype none

module block_lifo
	import stream_pkg::*;
#(
	parameter type item_t = chan_sym_t,
	parameter int  DEPTH  = MAX_BLOCK_LEN
) (
	input  wire logic      clk,
	input  wire logic      wr_en_i,
	input  wire blk_addr_t wr_addr_i,
	input  wire item_t     wr_data_i,
	input  wire blk_addr_t rd_addr_i,
	output item_t          rd_data_o
);

	// one entry per trellis step of the block
	item_t mem [DEPTH];

	// write in step order
	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// registered read, the controller walks the address downwards
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

`default_nettype wire

// File: block_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module block_ctrl
	import stream_pkg::*;
(
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     start_i,
	input  wire blk_len_t blk_len_i,
	input  wire logic     sym_valid_i,
	input  wire logic     credit_return_i,
	output logic          wr_en_o,
	output blk_addr_t     wr_addr_o,
	output blk_addr_t     rd_addr_o,
	output logic          step_valid_o,
	output logic          step_last_o,
	output logic          beta_init_o,
	output logic          idle_o
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		BACKWARD
	} ctrl_state_t;

	ctrl_state_t state_q;
	blk_addr_t   last_addr_q;
	blk_addr_t   wr_addr_q;
	blk_addr_t   rd_addr_q;
	credit_cnt_t credit_q;
	logic        load_done;
	logic        issue;

	assign idle_o      = (state_q == IDLE);
	assign beta_init_o = idle_o && start_i;
	assign wr_en_o     = (state_q == LOAD) && sym_valid_i;
	assign wr_addr_o   = wr_addr_q;
	assign rd_addr_o   = rd_addr_q;
	assign load_done   = wr_en_o && (wr_addr_q == last_addr_q);

	// one step per cycle while a credit is in hand
	assign issue = (state_q == BACKWARD) && (credit_q != '0);

	//////////////////////////////////////////////////
	// phase machine and addresses
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q     <= IDLE;
			last_addr_q <= '0;
			wr_addr_q   <= '0;
			rd_addr_q   <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					if (start_i) begin
						state_q     <= LOAD;
						last_addr_q <= blk_addr_t'(blk_len_i - blk_len_t'(1));
						wr_addr_q   <= '0;
					end
				end
				LOAD: begin
					if (load_done) begin
						state_q   <= BACKWARD;
						rd_addr_q <= last_addr_q;
					end else if (wr_en_o) begin
						wr_addr_q <= wr_addr_q + blk_addr_t'(1);
					end
				end
				BACKWARD: begin
					if (issue) begin
						if (rd_addr_q == '0) begin
							state_q <= IDLE;
						end else begin
							rd_addr_q <= rd_addr_q - blk_addr_t'(1);
						end
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// buffer data shows up one cycle after issue
	always_ff @(posedge clk) begin
		if (rst) begin
			step_valid_o <= 1'b0;
			step_last_o  <= 1'b0;
		end else begin
			step_valid_o <= issue;
			step_last_o  <= issue && (rd_addr_q == '0);
		end
	end

	//////////////////////////////////////////////////
	// credits
	//////////////////////////////////////////////////

	// return and spend in the same cycle cancel out
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_q <= CREDIT_MAX;
		end else if (credit_return_i && !issue) begin
			credit_q <= credit_q + credit_cnt_t'(1);
		end else if (issue && !credit_return_i) begin
			credit_q <= credit_q - credit_cnt_t'(1);
		end
	end

	// consumer never returns more than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credit_q <= CREDIT_MAX)
		else $error("credit count above CREDIT_MAX");

	a_sym_in_load: assert property (@(posedge clk) disable iff (rst)
		sym_valid_i |-> (state_q == LOAD))
		else $error("input beat outside load phase");

	// an empty credit counter freezes the backward walk
	a_issue_credit: assert property (@(posedge clk) disable iff (rst)
		(state_q == BACKWARD && credit_q == '0)
		|=> (state_q == BACKWARD && !step_valid_o && $stable(rd_addr_q)))
		else $error("step issued without credit");

endmodule

`default_nettype wire

// File: beta_recursion.sv
`timescale 1ns/100ps
`default_nettype none

module beta_recursion
	import siso_pkg::*;
	import stream_pkg::*;
(
	input  wire logic      clk,
	input  wire logic      rst,
	input  wire logic      beta_init_i,
	input  wire logic      step_valid_i,
	input  wire chan_sym_t chan_i,
	output state_metrics_t beta_o
);

	state_metrics_t beta_q;
	state_metrics_t beta_upd;
	state_metrics_t beta_norm;

	// butterfly, each state takes the better of its two successors
	always_comb begin
		for (int s = 0; s < NUM_STATES; s++) begin
			beta_upd[s] = metric_max(
				beta_q[NEXT_ZERO[s]] + sel_branch(s, chan_i.g1, chan_i.g2),
				beta_q[NEXT_ONE[s]] - sel_branch(s, chan_i.g1, chan_i.g2));
		end
	end

	// keep state 0 at zero so the metrics stay bounded
	always_comb begin
		for (int s = 0; s < NUM_STATES; s++) begin
			beta_norm[s] = beta_upd[s] - beta_upd[0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst || beta_init_i) begin
			for (int s = 0; s < NUM_STATES; s++) begin
				beta_q[s] <= (s == 0) ? metric_t'(0) : BETA_INIT_OTHER;
			end
		end else if (step_valid_i) begin
			beta_q <= beta_norm;
		end
	end

	// held value is beta of the step after the one being processed
	assign beta_o = beta_q;

endmodule

`default_nettype wire

// File: llr_unit.sv
`timescale 1ns/100ps
`default_nettype none

module llr_unit
	import siso_pkg::*;
	import stream_pkg::*;
(
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           step_valid_i,
	input  wire logic           step_last_i,
	input  wire chan_sym_t      chan_i,
	input  wire alpha_sym_t     alpha_i,
	input  wire state_metrics_t beta_i,
	output ext_out_t            ext_o,
	output logic                ext_valid_o
);

	// per step values that ride along with the metrics
	typedef struct packed {
		metric_t sys;
		metric_t apriori;
		logic    last;
	} side_t;

	side_t          side_q [2];
	logic [1:0]     valid_q;
	state_metrics_t branch;
	state_metrics_t one_q;
	state_metrics_t zero_q;
	metric_t        one_pair_q [4];
	metric_t        zero_pair_q [4];
	metric_t        one_best;
	metric_t        zero_best;
	metric_t        llr;
	metric_t        diff;
	metric_t        tripled;

	always_comb begin
		for (int s = 0; s < NUM_STATES; s++) begin
			branch[s] = sel_branch(s, chan_i.g1, chan_i.g2);
		end
	end

	//////////////////////////////////////////////////
	// stage 1, transition metrics
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int s = 0; s < NUM_STATES; s++) begin
			one_q[s]  <= alpha_i.alpha[s] - branch[s] + beta_i[NEXT_ONE[s]];
			zero_q[s] <= alpha_i.alpha[s] + branch[s] + beta_i[NEXT_ZERO[s]];
		end
		side_q[0] <= '{sys: chan_i.sys, apriori: chan_i.apriori, last: step_last_i};
	end

	//////////////////////////////////////////////////
	// stage 2, pairwise maxima
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			one_pair_q[i]  <= metric_max(one_q[2*i], one_q[2*i+1]);
			zero_pair_q[i] <= metric_max(zero_q[2*i], zero_q[2*i+1]);
		end
		side_q[1] <= side_q[0];
	end

	//////////////////////////////////////////////////
	// stage 3, llr and extrinsic
	//////////////////////////////////////////////////

	always_comb begin
		one_best  = metric_max(metric_max(one_pair_q[0], one_pair_q[1]),
			metric_max(one_pair_q[2], one_pair_q[3]));
		zero_best = metric_max(metric_max(zero_pair_q[0], zero_pair_q[1]),
			metric_max(zero_pair_q[2], zero_pair_q[3]));
		llr       = one_best - zero_best;
		diff      = llr - side_q[1].sys - side_q[1].apriori;
		// times 0.75, floor rounding from the arithmetic shift
		tripled   = diff + (diff <<< 1);
	end

	always_ff @(posedge clk) begin
		ext_o.extrinsic <= tripled >>> 2;
		ext_o.last      <= side_q[1].last;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q     <= '0;
			ext_valid_o <= 1'b0;
		end else begin
			valid_q     <= {valid_q[0], step_valid_i};
			ext_valid_o <= valid_q[1];
		end
	end

endmodule

`default_nettype wire

// File: beta_llr_top.sv
`timescale 1ns/100ps
`default_nettype none

module beta_llr_top
	import siso_pkg::*;
	import stream_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       rst,
	input  wire logic       start_i,
	input  wire blk_len_t   blk_len_i,
	input  wire logic       sym_valid_i,
	input  wire chan_sym_t  chan_i,
	input  wire alpha_sym_t alpha_i,
	input  wire logic       credit_return_i,
	output ext_out_t        ext_o,
	output logic            ext_valid_o,
	output logic            idle_o
);

	logic           wr_en;
	blk_addr_t      wr_addr;
	blk_addr_t      rd_addr;
	logic           step_valid;
	logic           step_last;
	logic           beta_init;
	chan_sym_t      chan_rd;
	alpha_sym_t     alpha_rd;
	state_metrics_t beta;

	block_ctrl block_ctrl_inst (
		.clk             (clk),
		.rst             (rst),
		.start_i         (start_i),
		.blk_len_i       (blk_len_i),
		.sym_valid_i     (sym_valid_i),
		.credit_return_i (credit_return_i),
		.wr_en_o         (wr_en),
		.wr_addr_o       (wr_addr),
		.rd_addr_o       (rd_addr),
		.step_valid_o    (step_valid),
		.step_last_o     (step_last),
		.beta_init_o     (beta_init),
		.idle_o          (idle_o)
	);

	//////////////////////////////////////////////////
	// block buffers, one writer and one reader each
	//////////////////////////////////////////////////

	block_lifo #(
		.item_t (chan_sym_t),
		.DEPTH  (MAX_BLOCK_LEN)
	) chan_lifo_inst (
		.clk       (clk),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (chan_i),
		.rd_addr_i (rd_addr),
		.rd_data_o (chan_rd)
	);

	block_lifo #(
		.item_t (alpha_sym_t),
		.DEPTH  (MAX_BLOCK_LEN)
	) alpha_lifo_inst (
		.clk       (clk),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_data_i (alpha_i),
		.rd_addr_i (rd_addr),
		.rd_data_o (alpha_rd)
	);

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	beta_recursion beta_recursion_inst (
		.clk          (clk),
		.rst          (rst),
		.beta_init_i  (beta_init),
		.step_valid_i (step_valid),
		.chan_i       (chan_rd),
		.beta_o       (beta)
	);

	llr_unit llr_unit_inst (
		.clk          (clk),
		.rst          (rst),
		.step_valid_i (step_valid),
		.step_last_i  (step_last),
		.chan_i       (chan_rd),
		.alpha_i      (alpha_rd),
		.beta_i       (beta),
		.ext_o        (ext_o),
		.ext_valid_o  (ext_valid_o)
	);

endmodule

`default_nettype wire

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

//////////////////////////////////////////////////
// reference model of one block
//////////////////////////////////////////////////

// block data as it is fed to the DUT
chan_sym_t  model_chan  [MAX_BLOCK_LEN];
alpha_sym_t model_alpha [MAX_BLOCK_LEN];

// expected results in output order
ext_out_t exp_q [$];

// states 2 to 5 take g2, the rest g1
function automatic metric_t branch_of(input int s, input chan_sym_t c);
	return (s >= 2 && s <= 5) ? c.g2 : c.g1;
endfunction

function automatic metric_t larger(input metric_t a, input metric_t b);
	return (a > b) ? a : b;
endfunction

// walks the block backwards and queues one result per step
task automatic model_block(input int len);
	state_metrics_t beta;
	state_metrics_t nb;
	metric_t        br;
	metric_t        best1;
	metric_t        best0;
	metric_t        llr;
	metric_t        diff;
	metric_t        tripled;
	ext_out_t       e;
	for (int s = 0; s < NUM_STATES; s++) begin
		beta[s] = (s == 0) ? metric_t'(0) : metric_t'(-128);
	end
	for (int k = len - 1; k >= 0; k--) begin
		best1 = metric_t'(-32768);
		best0 = metric_t'(-32768);
		for (int s = 0; s < NUM_STATES; s++) begin
			br    = branch_of(s, model_chan[k]);
			best1 = larger(best1, model_alpha[k].alpha[s] - br + beta[NEXT_ONE[s]]);
			best0 = larger(best0, model_alpha[k].alpha[s] + br + beta[NEXT_ZERO[s]]);
		end
		llr     = best1 - best0;
		diff    = llr - model_chan[k].sys - model_chan[k].apriori;
		// three quarters, rounded toward minus infinity
		tripled = diff * metric_t'(3);
		e.extrinsic = tripled >>> 2;
		e.last      = (k == 0);
		exp_q.push_back(e);
		// beta of step k from beta of step k+1
		for (int s = 0; s < NUM_STATES; s++) begin
			br    = branch_of(s, model_chan[k]);
			nb[s] = larger(beta[NEXT_ZERO[s]] + br, beta[NEXT_ONE[s]] - br);
		end
		for (int s = 0; s < NUM_STATES; s++) begin
			beta[s] = nb[s] - nb[0];
		end
	end
endtask

`endif

// File: tb_beta_llr.sv
`timescale 1ns/100ps
`default_nettype none

module tb_beta_llr
	import siso_pkg::*;
	import stream_pkg::*;
;

	localparam int T3_LEN     = 32;
	localparam int NUM_BLOCKS = 13;

	logic       clk;
	logic       rst;
	logic       start_i;
	blk_len_t   blk_len_i;
	logic       sym_valid_i;
	chan_sym_t  chan_i;
	alpha_sym_t alpha_i;
	logic       credit_return_i;
	ext_out_t   ext_o;
	logic       ext_valid_o;
	logic       idle_o;

	int errors           = 0;
	int checked          = 0;
	int cyc              = 0;
	int cycle_limit      = 0;
	int credit_delay_max = 0;
	int received_cnt     = 0;
	int returned_cnt     = 0;
	int due_q [$];
	int len5 [10];

	`include "tb_model.svh"

	beta_llr_top beta_llr_top_inst (
		.clk             (clk),
		.rst             (rst),
		.start_i         (start_i),
		.blk_len_i       (blk_len_i),
		.sym_valid_i     (sym_valid_i),
		.chan_i          (chan_i),
		.alpha_i         (alpha_i),
		.credit_return_i (credit_return_i),
		.ext_o           (ext_o),
		.ext_valid_o     (ext_valid_o),
		.idle_o          (idle_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// checks and helpers
	//////////////////////////////////////////////////

	task automatic compare_ext(input ext_out_t got, input ext_out_t exp);
		if (got.extrinsic !== exp.extrinsic) begin
			$display("MISMATCH ext_o.extrinsic result %0d: got %h expected %h",
				checked, got.extrinsic, exp.extrinsic);
			errors++;
		end
		if (got.last !== exp.last) begin
			$display("MISMATCH ext_o.last result %0d: got %h expected %h",
				checked, got.last, exp.last);
			errors++;
		end
	endtask

	task automatic compare_credit(input credit_cnt_t outstanding);
		if (outstanding > CREDIT_MAX) begin
			$display("outputs awaiting credit went above CREDIT_MAX: %0d", outstanding);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
		end
	endtask

	// near_limit picks values within 64 of either 16-bit end
	function automatic metric_t rand_metric(input bit near_limit);
		int r;
		if (near_limit) begin
			r = int'($urandom_range(0, 63));
			return ($urandom_range(0, 1) == 1) ? metric_t'(32767 - r) : metric_t'(-32768 + r);
		end
		return metric_t'(int'($urandom_range(0, 1023)) - 512);
	endfunction

	// fills the model, waits for idle and feeds one block
	task automatic run_block(input int len, input bit near_limit);
		for (int k = 0; k < len; k++) begin
			model_chan[k].sys     = rand_metric(near_limit);
			model_chan[k].apriori = rand_metric(near_limit);
			model_chan[k].g1      = rand_metric(near_limit);
			model_chan[k].g2      = rand_metric(near_limit);
			for (int s = 0; s < NUM_STATES; s++) begin
				model_alpha[k].alpha[s] = rand_metric(near_limit);
			end
		end
		model_block(len);
		while (!idle_o) begin
			@(negedge clk);
		end
		start_i   = 1'b1;
		blk_len_i = blk_len_t'(len);
		@(negedge clk);
		start_i = 1'b0;
		for (int k = 0; k < len; k++) begin
			// occasional gap between beats
			if ($urandom_range(0, 3) == 0) begin
				sym_valid_i = 1'b0;
				@(negedge clk);
			end
			sym_valid_i = 1'b1;
			chan_i      = model_chan[k];
			alpha_i     = model_alpha[k];
			@(negedge clk);
		end
		sym_valid_i = 1'b0;
	endtask

	// all results seen and all credits handed back
	task automatic drain();
		while (exp_q.size() != 0 || due_q.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
	endtask

	//////////////////////////////////////////////////
	// consumer, checks outputs and returns credits
	//////////////////////////////////////////////////

	initial begin : consumer
		int       idx;
		int       outstanding;
		ext_out_t expected;
		credit_return_i = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				credit_return_i = 1'b0;
			end else begin
				if (ext_valid_o) begin
					if (exp_q.size() == 0) begin
						$display("output appeared with no result pending");
						errors++;
					end else begin
						expected = exp_q.pop_front();
						compare_ext(ext_o, expected);
						checked++;
					end
					received_cnt++;
					due_q.push_back(cyc + int'($urandom_range(0, credit_delay_max)));
				end
				outstanding = received_cnt - returned_cnt;
				compare_credit(credit_cnt_t'((outstanding > 7) ? 7 : outstanding));
				// one credit per cycle at most, oldest due first
				idx = -1;
				for (int i = 0; i < due_q.size(); i++) begin
					if (idx < 0 && due_q[i] <= cyc) begin
						idx = i;
					end
				end
				if (idx >= 0) begin
					due_q.delete(idx);
					returned_cnt++;
					credit_return_i = 1'b1;
				end else begin
					credit_return_i = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		while (cycle_limit == 0 || cyc < cycle_limit) begin
			@(posedge clk);
			cyc++;
		end
		$display("timeout after %0d cycles, DUT stopped producing results", cyc);
		$display("Regression failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		int total;
		int errs_before;
		rst         = 1'b1;
		start_i     = 1'b0;
		blk_len_i   = '0;
		sym_valid_i = 1'b0;
		chan_i      = '0;
		alpha_i     = '0;
		void'($urandom(32'h154f9db0));
		total       = 0;
		for (int i = 0; i < 10; i++) begin
			len5[i] = int'($urandom_range(1, 40));
			total += len5[i];
		end
		cycle_limit = 8 * ((8 + T3_LEN + MAX_BLOCK_LEN + total) + 20 * NUM_BLOCKS);
		repeat (16) @(negedge clk);
		rst = 1'b0;

		errs_before = errors;
		@(negedge clk);
		check_bit("ext_valid_o", ext_valid_o, 1'b0);
		check_bit("idle_o", idle_o, 1'b1);
		report_test("1 reset state", errs_before);

		errs_before      = errors;
		credit_delay_max = 0;
		run_block(8, 1'b0);
		drain();
		report_test("2 single block", errs_before);

		errs_before      = errors;
		credit_delay_max = 6;
		run_block(T3_LEN, 1'b0);
		drain();
		report_test("3 slow credit return", errs_before);

		errs_before      = errors;
		credit_delay_max = 0;
		run_block(MAX_BLOCK_LEN, 1'b1);
		drain();
		report_test("4 full length near limits", errs_before);

		errs_before      = errors;
		credit_delay_max = 2;
		for (int i = 0; i < 10; i++) begin
			run_block(len5[i], 1'b0);
		end
		drain();
		report_test("5 back to back blocks", errs_before);

		$display("results checked %0d, credits returned %0d, errors %0d",
			checked, returned_cnt, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
siso_pkg.sv
stream_pkg.sv
block_lifo.sv
block_ctrl.sv
beta_recursion.sv
llr_unit.sv
beta_llr_top.sv
tb_beta_llr.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module tb_beta_llr -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -q "Regression passed"
